/* all.f */
a2_card_pkg.sv
a2_card_regs.sv
card_bus_arbiter.sv
audio_mixer.sv
scanline_shader.sv
panel_io.sv
a2_card_top.sv
a2_card_props.sv
tb_a2_card.sv

/* run_sim.sh */
#!/bin/sh
# Builds the card glue testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module tb_a2_card -f all.f -o sim_a2_card
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_a2_card +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "FAIL: the testbench reported failures"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

echo "PASS"
exit 0

/* tb_a2_card.sv */
// Testbench for the card glue top, random bus, audio and video streams plus APB and panel checks
`timescale 1ns/10ps
`default_nettype none

module tb_a2_card;

    import a2_card_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int DEBOUNCE      = 8;
    localparam int STREAM_CYCLES = 300;
    localparam int RUN_CYCLES    = 4 * STREAM_CYCLES + 600;    // Stream phases plus margin
    localparam logic [31:0] SEED = 32'd3833;
    localparam bit SCAN_RST = 1'b1;
    localparam bit SPK_RST  = 1'b0;
    localparam bit IRQ_RST  = 1'b1;
    localparam bit DOUT_RST = 1'b0;

    logic          clk_logic_w;
    logic          rst_i;
    apb_req_t      apb_req;
    apb_rsp_t      apb_rsp;
    card_reads_t   card_reads;
    card_byte_t    bus_data_in;
    logic [2:0]    card_irq_n;
    card_byte_t    bus_data_out;
    logic          bus_data_en;
    logic          irq_n;
    audio_src_t    audio_in;
    stereo_t       audio_out;
    rgb_t          pixel_in;
    screen_coord_t screen_y;
    rgb_t          pixel_out;
    logic          button;
    mode_flags_t   mode_flags;
    logic [4:0]    led;
    logic [31:0]   stream_seed = SEED;
    logic [31:0]   panel_seed = SEED;
    logic          overlay_exp;

    a2_card_top #(
        .SCANLINES_ENABLE    (SCAN_RST),
        .APPLE_SPEAKER_ENABLE(SPK_RST),
        .IRQ_OUT_ENABLE      (IRQ_RST),
        .BUS_DATA_OUT_ENABLE (DOUT_RST),
        .DEBOUNCE_CYCLES     (DEBOUNCE)
    ) dut_i (
        .clk_logic_w  (clk_logic_w),
        .rst_i        (rst_i),
        .apb_req_i    (apb_req),
        .apb_rsp_o    (apb_rsp),
        .card_reads_i (card_reads),
        .bus_data_i   (bus_data_in),
        .card_irq_n_i (card_irq_n),
        .bus_data_o   (bus_data_out),
        .bus_data_en_o(bus_data_en),
        .irq_n_o      (irq_n),
        .audio_i      (audio_in),
        .audio_o      (audio_out),
        .pixel_i      (pixel_in),
        .screen_y_i   (screen_y),
        .pixel_o      (pixel_out),
        .button_i     (button),
        .mode_flags_i (mode_flags),
        .led_o        (led)
    );

    bind a2_card_top a2_card_props props_i (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .apb_req_i   (apb_req_i),
        .apb_rsp_i   (apb_rsp_o),
        .ctrl_i      (ctrl_w),
        .card_reads_i(card_reads_i),
        .bus_data_i  (bus_data_i),
        .card_irq_n_i(card_irq_n_i),
        .bus_out_i   (bus_data_o),
        .bus_en_i    (bus_data_en_o),
        .irq_n_i     (irq_n_o),
        .audio_i     (audio_i),
        .audio_out_i (audio_o),
        .pixel_i     (pixel_i),
        .screen_y_i  (screen_y_i),
        .pixel_out_i (pixel_o),
        .mode_flags_i(mode_flags_i),
        .led_i       (led_o)
    );

    function automatic logic [31:0] lcg(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // One new datapath item per cycle
    task automatic drive_datapath();
        for (int i = 0; i < NUM_CARD_SRC; i++) begin
            stream_seed = lcg(stream_seed);
            card_reads[i].rd_en = (stream_seed[31:30] == 2'b00);   // About one in four reads
            card_reads[i].data  = stream_seed[23:16];
        end
        stream_seed = lcg(stream_seed);
        bus_data_in = stream_seed[31:24];
        card_irq_n  = stream_seed[22:20];
        screen_y    = stream_seed[17:8];
        stream_seed = lcg(stream_seed);
        pixel_in    = stream_seed[31:8];
        stream_seed = lcg(stream_seed);
        audio_in.sg_l = stream_seed[31:16];
        audio_in.sg_r = stream_seed[23:8];
        if (stream_seed[7:6] == 2'b00) begin
            audio_in.sg_l = {6'b011111, stream_seed[25:16]};     // Close to positive full scale
        end
        if (stream_seed[5:4] == 2'b00) begin
            audio_in.sg_r = {6'b100000, stream_seed[17:8]};
        end
        stream_seed = lcg(stream_seed);
        audio_in.ssp     = stream_seed[31:22];
        audio_in.mb_l    = stream_seed[21:12];
        audio_in.mb_r    = stream_seed[15:6];
        audio_in.speaker = stream_seed[28];
    endtask

    // Setup, access, wait for pready, then release at the next falling edge
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        int waits;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk_logic_w);
        apb_req.penable = 1'b1;
        waits = 0;
        @(negedge clk_logic_w);
        while (!apb_rsp.pready) begin
            waits++;
            @(negedge clk_logic_w);
        end
        check_value("extra APB wait cycles", 32'(waits), 32'd0);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk_logic_w);
        apb_req = '0;
    endtask

    task automatic reg_read_check(input apb_addr_t addr, input apb_data_t exp,
                                  input logic exp_err, input string what);
        apb_data_t rdata;
        logic      err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_value({what, " pslverr"}, 32'(err), 32'(exp_err));
        if (!exp_err) begin
            check_value(what, rdata, exp);
        end
    endtask

    task automatic reg_write_check(input apb_addr_t addr, input apb_data_t data,
                                   input logic exp_err, input string what);
        apb_data_t rdata;
        logic      err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value({what, " pslverr"}, 32'(err), 32'(exp_err));
    endtask

    // Press, release long enough to settle, and update the overlay model
    task automatic press_button(input int hold_cycles);
        button = 1'b1;
        repeat (hold_cycles) @(negedge clk_logic_w);
        button = 1'b0;
        repeat (DEBOUNCE + 4) @(negedge clk_logic_w);
        if (hold_cycles >= DEBOUNCE) begin
            overlay_exp = ~overlay_exp;
        end
    endtask

    task automatic status_check(input string what);
        panel_seed = lcg(panel_seed);
        mode_flags = panel_seed[31:27];
        @(negedge clk_logic_w);
        reg_read_check(REG_STATUS_ADDR, {26'd0, mode_flags, overlay_exp}, 1'b0, what);
    endtask

    task automatic stream_with_ctrl(input logic [3:0] ctrl);
        reg_write_check(REG_CTRL_ADDR, {28'd0, ctrl}, 1'b0, "CTRL write");
        reg_read_check(REG_CTRL_ADDR, {28'd0, ctrl}, 1'b0, "CTRL readback");
        repeat (STREAM_CYCLES) @(negedge clk_logic_w);
    endtask

    initial begin
        clk_logic_w = 1'b0;
        forever #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;
    end

    // Datapath stimulus, one item on every falling edge
    initial begin
        card_reads  = '0;
        bus_data_in = '0;
        card_irq_n  = '1;
        audio_in    = '0;
        pixel_in    = '0;
        screen_y    = '0;
        forever begin
            @(negedge clk_logic_w);
            drive_datapath();
        end
    end

    always @(negedge clk_logic_w) begin
        if (dut_i.props_i.any_fail_w) begin
            $display("a bound datapath or APB assertion failed at %0t ns", $time);
            abort_run();
        end
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", RUN_CYCLES);
        abort_run();
    end

    initial begin
        rst_i       = 1'b1;
        apb_req     = '0;
        button      = 1'b0;
        mode_flags  = '0;
        overlay_exp = 1'b0;
        repeat (3) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        rst_i = 1'b0;
        check_value("led after reset", 32'(led), 32'h1f);
        check_value("bus enable after reset", 32'(bus_data_en), 32'd0);
        reg_read_check(REG_CTRL_ADDR, {28'd0, SCAN_RST, SPK_RST, IRQ_RST, DOUT_RST}, 1'b0,
                       "CTRL after reset");
        status_check("STATUS after reset");
        repeat (STREAM_CYCLES) @(negedge clk_logic_w);
        stream_with_ctrl(4'hf);
        stream_with_ctrl(4'h0);     // Enable low, irq released, no speaker, no dimming
        stream_with_ctrl(4'h5);
        reg_read_check(4'h8, '0, 1'b1, "unmapped read");
        reg_write_check(4'hc, 32'hf, 1'b1, "unmapped write");
        reg_write_check(REG_STATUS_ADDR, 32'h3f, 1'b1, "STATUS write");
        reg_read_check(REG_CTRL_ADDR, 32'h5, 1'b0, "CTRL after refused writes");
        status_check("STATUS after refused writes");
        press_button(DEBOUNCE - 1);
        status_check("overlay after short glitch");
        press_button(DEBOUNCE);
        status_check("overlay after press");
        press_button(DEBOUNCE + 5);
        status_check("overlay after second press");
        if (dut_i.props_i.any_fail_w) begin
            $display("a bound assertion failed near the end of the run");
            abort_run();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* a2_card_props.sv */
// Bound checker for the one-cycle card datapath rules and the APB wait state, bind to a2_card_top
`timescale 1ns/10ps
`default_nettype none

module a2_card_props (
    input wire                             clk_logic_w,
    input wire                             rst_i,
    input wire a2_card_pkg::apb_req_t      apb_req_i,
    input wire a2_card_pkg::apb_rsp_t      apb_rsp_i,
    input wire a2_card_pkg::ctrl_t         ctrl_i,
    input wire a2_card_pkg::card_reads_t   card_reads_i,
    input wire a2_card_pkg::card_byte_t    bus_data_i,
    input wire [2:0]                       card_irq_n_i,
    input wire a2_card_pkg::card_byte_t    bus_out_i,
    input wire                             bus_en_i,
    input wire                             irq_n_i,
    input wire a2_card_pkg::audio_src_t    audio_i,
    input wire a2_card_pkg::stereo_t       audio_out_i,
    input wire a2_card_pkg::rgb_t          pixel_i,
    input wire a2_card_pkg::screen_coord_t screen_y_i,
    input wire a2_card_pkg::rgb_t          pixel_out_i,
    input wire a2_card_pkg::mode_flags_t   mode_flags_i,
    input wire [4:0]                       led_i
);

    import a2_card_pkg::*;

    logic rst_q = 1'b1;         // Masks the first edge out of reset
    logic access_w;
    logic bus_fail = 1'b0;
    logic irq_fail = 1'b0;
    logic audio_fail = 1'b0;
    logic pixel_fail = 1'b0;
    logic led_fail = 1'b0;
    logic late_fail = 1'b0;
    logic due_fail = 1'b0;
    logic any_fail_w;

    // Serial first, card ROM last
    function automatic card_byte_t pick_byte(input card_reads_t rd, input card_byte_t bus);
        card_byte_t res;
        logic       found;
        res = bus;
        found = 1'b0;
        for (int i = 0; i < NUM_CARD_SRC; i++) begin
            if (!found && rd[i].rd_en) begin
                res = rd[i].data;
                found = 1'b1;
            end
        end
        return res;
    endfunction

    function automatic logic reads_any(input card_reads_t rd);
        logic any;
        any = 1'b0;
        for (int i = 0; i < NUM_CARD_SRC; i++) begin
            any = any | rd[i].rd_en;
        end
        return any;
    endfunction

    function automatic audio_sample_t mix_chan(input audio_sample_t sg, input card_audio_t ssp,
                                               input card_audio_t mb, input logic spk);
        int s;
        s = int'(sg) + 8 * int'(ssp) + 8 * int'(mb);
        if (spk) begin
            s = s + 4096;
        end
        if (s > 32767) begin
            s = 32767;
        end else if (s < -32768) begin
            s = -32768;
        end
        return s[15:0];
    endfunction

    function automatic rgb_t shade(input rgb_t p, input logic dim);
        rgb_t res;
        res = p;
        if (dim) begin
            res.r = p.r / 8'd2;
            res.g = p.g / 8'd2;
            res.b = p.b / 8'd2;
        end
        return res;
    endfunction

    always @(posedge clk_logic_w) begin
        rst_q <= rst_i;
    end

    assign access_w   = apb_req_i.psel && apb_req_i.penable;
    assign any_fail_w = bus_fail | irq_fail | audio_fail | pixel_fail | led_fail
                      | late_fail | due_fail;

    a_bus: assert property (@(posedge clk_logic_w) disable iff (rst_i || rst_q)
        {bus_en_i, bus_out_i} == {$past(ctrl_i.data_out_en) && reads_any($past(card_reads_i)),
                                  pick_byte($past(card_reads_i), $past(bus_data_i))})
        else begin $error("bus data or enable off the priority rule"); bus_fail = 1'b1; end

    a_irq: assert property (@(posedge clk_logic_w) disable iff (rst_i || rst_q)
        irq_n_i == (!$past(ctrl_i.irq_out_en) || (&$past(card_irq_n_i))))
        else begin $error("irq_n does not follow the card lines"); irq_fail = 1'b1; end

    a_audio: assert property (@(posedge clk_logic_w) disable iff (rst_i || rst_q)
        audio_out_i.l == mix_chan($past(audio_i.sg_l), $past(audio_i.ssp), $past(audio_i.mb_l),
                                  $past(audio_i.speaker && ctrl_i.speaker_en))
        && audio_out_i.r == mix_chan($past(audio_i.sg_r), $past(audio_i.ssp),
                                     $past(audio_i.mb_r),
                                     $past(audio_i.speaker && ctrl_i.speaker_en)))
        else begin $error("stereo mix mismatch"); audio_fail = 1'b1; end

    a_pixel: assert property (@(posedge clk_logic_w) disable iff (rst_i || rst_q)
        pixel_out_i == shade($past(pixel_i), $past(ctrl_i.scanlines_en && screen_y_i[0])))
        else begin $error("scanline pixel mismatch"); pixel_fail = 1'b1; end

    a_led: assert property (@(posedge clk_logic_w) disable iff (rst_i || rst_q)
        led_i == ~$past(mode_flags_i))
        else begin $error("led is not the inverted mode flags"); led_fail = 1'b1; end

    // Completion only after one full wait cycle
    a_pready_late: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        apb_rsp_i.pready |-> access_w && $past(access_w && !apb_rsp_i.pready))
        else begin $error("pready without a wait cycle"); late_fail = 1'b1; end

    a_pready_due: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        $rose(access_w) |=> apb_rsp_i.pready)
        else begin $error("pready missing on the second access cycle"); due_fail = 1'b1; end

endmodule

`default_nettype wire

/* a2_card_top.sv */
// Card glue top level, ties the APB register block to the bus, audio, video and panel paths
`timescale 1ns/10ps
`default_nettype none

module a2_card_top #(
    parameter bit SCANLINES_ENABLE     = 1'b0,
    parameter bit APPLE_SPEAKER_ENABLE = 1'b0,
    parameter bit IRQ_OUT_ENABLE       = 1'b1,
    parameter bit BUS_DATA_OUT_ENABLE  = 1'b1,
    parameter int DEBOUNCE_CYCLES      = 10000
) (
    input  wire                             clk_logic_w,
    input  wire                             rst_i,

    input  wire a2_card_pkg::apb_req_t      apb_req_i,
    output a2_card_pkg::apb_rsp_t           apb_rsp_o,

    input  wire a2_card_pkg::card_reads_t   card_reads_i,
    input  wire a2_card_pkg::card_byte_t    bus_data_i,
    input  wire [2:0]                       card_irq_n_i,
    output a2_card_pkg::card_byte_t         bus_data_o,
    output logic                            bus_data_en_o,
    output logic                            irq_n_o,

    input  wire a2_card_pkg::audio_src_t    audio_i,
    output a2_card_pkg::stereo_t            audio_o,

    input  wire a2_card_pkg::rgb_t          pixel_i,
    input  wire a2_card_pkg::screen_coord_t screen_y_i,
    output a2_card_pkg::rgb_t               pixel_o,

    input  wire                             button_i,
    input  wire a2_card_pkg::mode_flags_t   mode_flags_i,
    output logic [4:0]                      led_o
);

    import a2_card_pkg::*;

    ctrl_t ctrl_w;          // Enable bits from the host
    logic  overlay_on_w;

    a2_card_regs #(
        .SCANLINES_ENABLE    (SCANLINES_ENABLE),
        .APPLE_SPEAKER_ENABLE(APPLE_SPEAKER_ENABLE),
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE),
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE)
    ) regs_i (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .apb_req_i   (apb_req_i),
        .apb_rsp_o   (apb_rsp_o),
        .overlay_on_i(overlay_on_w),
        .mode_flags_i(mode_flags_i),
        .ctrl_o      (ctrl_w)
    );

    card_bus_arbiter arbiter_i (
        .clk_logic_w  (clk_logic_w),
        .rst_i        (rst_i),
        .card_reads_i (card_reads_i),
        .bus_data_i   (bus_data_i),
        .card_irq_n_i (card_irq_n_i),
        .irq_out_en_i (ctrl_w.irq_out_en),
        .data_out_en_i(ctrl_w.data_out_en),
        .bus_data_o   (bus_data_o),
        .bus_data_en_o(bus_data_en_o),
        .irq_n_o      (irq_n_o)
    );

    audio_mixer mixer_i (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .audio_i     (audio_i),
        .speaker_en_i(ctrl_w.speaker_en),
        .audio_o     (audio_o)
    );

    scanline_shader shader_i (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst_i),
        .pixel_i       (pixel_i),
        .screen_y_i    (screen_y_i),
        .scanlines_en_i(ctrl_w.scanlines_en),
        .pixel_o       (pixel_o)
    );

    panel_io #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) panel_i (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .button_i    (button_i),
        .mode_flags_i(mode_flags_i),
        .overlay_on_o(overlay_on_w),
        .led_o       (led_o)
    );

endmodule

`default_nettype wire

/* panel_io.sv */
// Front panel button debounce with overlay toggle, and LED drive from the memory mode flags
`timescale 1ns/10ps
`default_nettype none

module panel_io #(
    parameter int DEBOUNCE_CYCLES = 10000
) (
    input  wire                           clk_logic_w,
    input  wire                           rst_i,
    input  wire                           button_i,
    input  wire a2_card_pkg::mode_flags_t mode_flags_i,
    output logic                          overlay_on_o,
    output logic [4:0]                    led_o
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] stable_cnt_q;     // Cycles the raw input has differed
    logic             btn_level_q;
    logic             btn_prev_q;
    logic             btn_rise_w;

    assign btn_rise_w = btn_level_q & ~btn_prev_q;

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            stable_cnt_q <= '0;
            btn_level_q  <= 1'b0;
            btn_prev_q   <= 1'b0;
            overlay_on_o <= 1'b0;
        end else begin
            btn_prev_q <= btn_level_q;
            if (button_i == btn_level_q) begin
                stable_cnt_q <= '0;             // Bounce back restarts the count
            end else if (stable_cnt_q == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                btn_level_q  <= button_i;
                stable_cnt_q <= '0;
            end else begin
                stable_cnt_q <= stable_cnt_q + 1'b1;
            end

            if (btn_rise_w) begin
                overlay_on_o <= ~overlay_on_o;
            end
        end
    end

    // LEDs are active low, text mode on the top bit
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            led_o <= '1;
        end else begin
            led_o <= ~{mode_flags_i.text, mode_flags_i.shrg, mode_flags_i.hires,
                       mode_flags_i.ramwrt, mode_flags_i.store80};
        end
    end

endmodule

`default_nettype wire

/* scanline_shader.sv */
// Halves each color channel on odd screen lines when the scanline effect is on
`timescale 1ns/10ps
`default_nettype none

module scanline_shader (
    input  wire                             clk_logic_w,
    input  wire                             rst_i,
    input  wire a2_card_pkg::rgb_t          pixel_i,
    input  wire a2_card_pkg::screen_coord_t screen_y_i,
    input  wire                             scanlines_en_i,
    output a2_card_pkg::rgb_t               pixel_o
);

    import a2_card_pkg::*;

    function automatic pixel_chan_t half(input pixel_chan_t c);
        return {1'b0, c[7:1]};
    endfunction

    logic dim_w;

    assign dim_w = scanlines_en_i & screen_y_i[0];  // Odd line

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            pixel_o <= '0;
        end else if (dim_w) begin
            pixel_o.r <= half(pixel_i.r);
            pixel_o.g <= half(pixel_i.g);
            pixel_o.b <= half(pixel_i.b);
        end else begin
            pixel_o <= pixel_i;
        end
    end

endmodule

`default_nettype wire

/* audio_mixer.sv */
// Widens the card audio sources and sums them with the Ensoniq pair into a saturated stereo sample
`timescale 1ns/10ps
`default_nettype none

module audio_mixer (
    input  wire                          clk_logic_w,
    input  wire                          rst_i,
    input  wire a2_card_pkg::audio_src_t audio_i,
    input  wire                          speaker_en_i,
    output a2_card_pkg::stereo_t         audio_o
);

    import a2_card_pkg::*;

    // 16-bit signed plus three 13-bit unsigned terms fits in 18 bits
    localparam int SUM_W = 18;

    typedef logic signed [SUM_W-1:0] mix_sum_t;

    localparam mix_sum_t SAMPLE_MAX = 18'sd32767;
    localparam mix_sum_t SAMPLE_MIN = -18'sd32768;
    localparam mix_sum_t SPEAKER_LVL = 18'sd4096;

    // Card level times 8, zero extended
    function automatic mix_sum_t widen8(input card_audio_t v);
        return {5'd0, v, 3'd0};
    endfunction

    function automatic audio_sample_t saturate(input mix_sum_t s);
        if (s > SAMPLE_MAX) begin
            return SAMPLE_MAX[15:0];
        end else if (s < SAMPLE_MIN) begin
            return SAMPLE_MIN[15:0];
        end
        return s[15:0];
    endfunction

    mix_sum_t ssp_w;
    mix_sum_t spk_w;
    mix_sum_t sum_l_w;
    mix_sum_t sum_r_w;

    assign ssp_w = widen8(audio_i.ssp);     // Mono sprite goes to both sides
    assign spk_w = (speaker_en_i && audio_i.speaker) ? SPEAKER_LVL : '0;

    assign sum_l_w = mix_sum_t'(audio_i.sg_l) + ssp_w + widen8(audio_i.mb_l) + spk_w;
    assign sum_r_w = mix_sum_t'(audio_i.sg_r) + ssp_w + widen8(audio_i.mb_r) + spk_w;

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            audio_o <= '0;
        end else begin
            audio_o.l <= saturate(sum_l_w);
            audio_o.r <= saturate(sum_r_w);
        end
    end

endmodule

`default_nettype wire

/* card_bus_arbiter.sv */
// Registered fixed-priority select of card read data onto the Apple bus, plus IRQ combining
`timescale 1ns/10ps
`default_nettype none

module card_bus_arbiter (
    input  wire                           clk_logic_w,
    input  wire                           rst_i,
    input  wire a2_card_pkg::card_reads_t card_reads_i,
    input  wire a2_card_pkg::card_byte_t  bus_data_i,
    input  wire [2:0]                     card_irq_n_i,
    input  wire                           irq_out_en_i,
    input  wire                           data_out_en_i,
    output a2_card_pkg::card_byte_t       bus_data_o,
    output logic                          bus_data_en_o,
    output logic                          irq_n_o
);

    import a2_card_pkg::*;

    card_byte_t sel_data_w;
    logic       any_rd_w;
    logic       irq_n_w;

    // Walk from lowest priority up so the lowest index is assigned last
    always_comb begin
        sel_data_w = bus_data_i;    // Nobody reading, bus byte passes
        any_rd_w   = 1'b0;
        for (int i = NUM_CARD_SRC - 1; i >= 0; i--) begin
            if (card_reads_i[i].rd_en) begin
                sel_data_w = card_reads_i[i].data;
                any_rd_w   = 1'b1;
            end
        end
    end

    // Open-drain style wired AND of the card interrupt lines
    assign irq_n_w = &card_irq_n_i;

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            bus_data_o    <= '0;
            bus_data_en_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            bus_data_o    <= sel_data_w;
            bus_data_en_o <= any_rd_w & data_out_en_i;
            irq_n_o       <= irq_out_en_i ? irq_n_w : 1'b1;  // Released when IRQ out is off
        end
    end

endmodule

`default_nettype wire

/* a2_card_regs.sv */
// APB register block with one wait state, holds the enable bits and returns panel status
`timescale 1ns/10ps
`default_nettype none

module a2_card_regs #(
    parameter bit SCANLINES_ENABLE     = 1'b0,
    parameter bit APPLE_SPEAKER_ENABLE = 1'b0,
    parameter bit IRQ_OUT_ENABLE       = 1'b1,
    parameter bit BUS_DATA_OUT_ENABLE  = 1'b1
) (
    input  wire                           clk_logic_w,
    input  wire                           rst_i,
    input  wire a2_card_pkg::apb_req_t    apb_req_i,
    output a2_card_pkg::apb_rsp_t         apb_rsp_o,
    input  wire                           overlay_on_i,
    input  wire a2_card_pkg::mode_flags_t mode_flags_i,
    output a2_card_pkg::ctrl_t            ctrl_o
);

    import a2_card_pkg::*;

    localparam ctrl_t CTRL_RESET = '{
        scanlines_en: SCANLINES_ENABLE,
        speaker_en:   APPLE_SPEAKER_ENABLE,
        irq_out_en:   IRQ_OUT_ENABLE,
        data_out_en:  BUS_DATA_OUT_ENABLE
    };

    ctrl_t     ctrl_q;
    logic      pready_q;
    logic      pslverr_q;
    apb_data_t prdata_q;

    logic      access_w;
    logic      ctrl_hit_w;
    logic      status_hit_w;
    logic      err_w;
    apb_data_t rdata_w;

    assign access_w     = apb_req_i.psel & apb_req_i.penable;
    assign ctrl_hit_w   = (apb_req_i.paddr == REG_CTRL_ADDR);
    assign status_hit_w = (apb_req_i.paddr == REG_STATUS_ADDR);

    // Unmapped, or an attempt to write the read-only status
    assign err_w = ~(ctrl_hit_w | status_hit_w) | (status_hit_w & apb_req_i.pwrite);

    always_comb begin
        rdata_w = '0;
        if (ctrl_hit_w) begin
            rdata_w[3:0] = ctrl_q;
        end else if (status_hit_w) begin
            rdata_w[0]   = overlay_on_i;
            rdata_w[5:1] = mode_flags_i;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            ctrl_q    <= CTRL_RESET;
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= access_w & ~pready_q;          // First access cycle is the wait state
            pslverr_q <= access_w & ~pready_q & err_w;
            // Write lands on the completing edge
            if (access_w && pready_q && apb_req_i.pwrite && ctrl_hit_w) begin
                ctrl_q <= apb_req_i.pwdata[3:0];
            end
        end
    end

    // Read data captured alongside pready
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            prdata_q <= '0;
        end else if (access_w && !pready_q) begin
            prdata_q <= rdata_w;
        end
    end

    assign apb_rsp_o.prdata  = prdata_q;
    assign apb_rsp_o.pready  = pready_q;
    assign apb_rsp_o.pslverr = pslverr_q;
    assign ctrl_o            = ctrl_q;

endmodule

`default_nettype wire

/* a2_card_pkg.sv */
// Shared widths, packed bus structs and APB register map, imported by the card glue modules
`default_nettype none

package a2_card_pkg;

    typedef logic [7:0] card_byte_t;            // Apple bus byte
    typedef logic [7:0] pixel_chan_t;
    typedef logic [9:0] screen_coord_t;
    typedef logic signed [15:0] audio_sample_t;
    typedef logic [9:0] card_audio_t;           // Unsigned card DAC level

    localparam int NUM_CARD_SRC = 5;

    typedef struct packed {
        logic       rd_en;
        card_byte_t data;
    } card_read_t;

    // Serial, sprite, Mockingboard, disk, card ROM
    typedef card_read_t [NUM_CARD_SRC-1:0] card_reads_t;

    typedef struct packed {
        pixel_chan_t r;
        pixel_chan_t g;
        pixel_chan_t b;
    } rgb_t;

    typedef struct packed {
        audio_sample_t sg_l;                    // Ensoniq left
        audio_sample_t sg_r;
        card_audio_t   ssp;                     // Sprite card, mono
        card_audio_t   mb_l;
        card_audio_t   mb_r;
        logic          speaker;
    } audio_src_t;

    typedef struct packed {
        audio_sample_t l;
        audio_sample_t r;
    } stereo_t;

    // Memory soft switch state as seen on the bus
    typedef struct packed {
        logic text;
        logic shrg;
        logic hires;
        logic ramwrt;
        logic store80;
    } mode_flags_t;

    typedef struct packed {
        logic scanlines_en;
        logic speaker_en;
        logic irq_out_en;
        logic data_out_en;
    } ctrl_t;

    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    localparam apb_addr_t REG_CTRL_ADDR   = 4'h0;   // ctrl_t in [3:0]
    localparam apb_addr_t REG_STATUS_ADDR = 4'h4;   // Overlay in [0], mode flags in [5:1]

endpackage

`default_nettype wire
